//--- hdl/ex_alu.sv
// ******************************
// 64-bit integer ALU, purely combinational.
// Covers add, subtract, logic ops, shifts and compares; compares
// return 0 or 1 in the low bit.
// ******************************

`timescale 1ns/10ps

module ex_alu (
  input  logic [ex_pkg::xlen-1:0] opa,
  input  logic [ex_pkg::xlen-1:0] opb,
  input  ex_pkg::alu_func_t       func,
  output logic [ex_pkg::xlen-1:0] result
);

  import ex_pkg::*;

  logic [shamt_bits-1:0] shamt;
  logic [xlen-1:0]       sra_fill;

  // Sign-aware less-than on two's complement values
  function automatic logic signed_lt(input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    if (a[xlen-1] == b[xlen-1]) begin
      return a < b;
    end
    return a[xlen-1];
  endfunction

  assign shamt = opb[shamt_bits-1:0];

  // Upper bits vacated by the logical right shift
  assign sra_fill = ~({xlen{1'b1}} >> shamt);

  always_comb begin
    case (func)
      alu_add:    result = opa + opb;
      alu_sub:    result = opa - opb;
      alu_and:    result = opa & opb;
      alu_bic:    result = opa & ~opb;
      alu_bis:    result = opa | opb;
      alu_ornot:  result = opa | ~opb;
      alu_xor:    result = opa ^ opb;
      alu_eqv:    result = opa ^ ~opb;
      alu_srl:    result = opa >> shamt;
      alu_sll:    result = opa << shamt;
      alu_sra:    result = (opa >> shamt) | (sra_fill & {xlen{opa[xlen-1]}});
      alu_cmpult: result = {{(xlen-1){1'b0}}, opa < opb};
      alu_cmpeq:  result = {{(xlen-1){1'b0}}, opa == opb};
      alu_cmpule: result = {{(xlen-1){1'b0}}, opa <= opb};
      alu_cmplt:  result = {{(xlen-1){1'b0}}, signed_lt(opa, opb)};
      alu_cmple:  result = {{(xlen-1){1'b0}}, signed_lt(opa, opb) || (opa == opb)};
      default:    result = alu_bad_code;
    endcase
  end

endmodule

//--- hdl/ex_arbiter.sv
// ******************************
// Completion bus arbiter, combinational.
// A finishing multiply takes the bus and stalls issue; otherwise
// an ALU or branch command completes in the cycle it is issued.
// ******************************

`timescale 1ns/10ps

module ex_arbiter (
  input  ex_pkg::ex_cmd_t         cmd,
  input  logic [ex_pkg::xlen-1:0] alu_result,
  input  logic                    cond,
  input  logic [ex_pkg::xlen-1:0] product,
  input  ex_pkg::mult_tag_t       mult_tag,
  input  logic                    wb_stall,
  output ex_pkg::cdb_t            cdb,
  output logic                    issue_stall
);

  import ex_pkg::*;

  logic issue_ok;

  assign issue_stall = mult_tag.valid || wb_stall;

  // Mult commands go to the pipeline and complete later
  assign issue_ok = cmd.valid && (cmd.kind != kind_mult) && !issue_stall;

  always_comb begin
    cdb = '0;
    if (mult_tag.valid) begin
      cdb.valid     = 1'b1;
      cdb.dest      = mult_tag.dest;
      cdb.result    = product;
      cdb.npc       = mult_tag.npc;
      cdb.target    = product;
      cdb.br_result = br_none;
    end else if (issue_ok) begin
      cdb.valid  = 1'b1;
      cdb.dest   = cmd.dest;
      cdb.npc    = cmd.npc;
      cdb.target = alu_result;
      if (cmd.kind == kind_branch) begin
        cdb.br_result  = cond ? br_taken : br_not_taken;
        cdb.mispredict = (cond != cmd.predicted_taken);
        // Link branches write the return address
        cdb.result     = cmd.is_link ? cmd.npc : alu_result;
      end else begin
        cdb.br_result = cmd.is_halt ? br_halt : br_none;
        cdb.result    = alu_result;
      end
    end
  end

endmodule

//--- hdl/ex_branch_cond.sv
// ******************************
// Branch condition on a single operand, combinational.
// cond high means the branch is taken.
// ******************************

`timescale 1ns/10ps

module ex_branch_cond (
  input  logic [ex_pkg::xlen-1:0] opa,
  input  ex_pkg::br_func_t        func,
  output logic                    cond
);

  import ex_pkg::*;

  logic raw;

  always_comb begin
    case (func.test)
      br_lbc:  raw = ~opa[0];
      br_eq:   raw = (opa == '0);
      br_lt:   raw = opa[xlen-1];
      default: raw = opa[xlen-1] || (opa == '0);
    endcase
  end

  // Top function bit flips the sense of the test
  assign cond = func.invert ? ~raw : raw;

endmodule

//--- hdl/ex_pkg.sv
// ******************************
// Shared definitions for the execute stage: data widths, ALU and
// branch function codes, branch outcomes and the packed structs for
// issued commands, multiplier tags and the completion bus.
// Modules import it inside their body.
// ******************************

package ex_pkg;

  localparam int xlen = 64;
  localparam int tag_bits = 8;
  localparam int mult_stages = 4;
  localparam int mult_chunk = 16;
  localparam int shamt_bits = $clog2(xlen);

  // Driven by the ALU on an undefined function code
  localparam logic [xlen-1:0] alu_bad_code = 64'hdead_beef_baad_beef;

  typedef enum logic [4:0] {
    alu_add, alu_sub,
    alu_and, alu_bic, alu_bis, alu_ornot, alu_xor, alu_eqv,
    alu_srl, alu_sll, alu_sra,
    alu_cmpult, alu_cmpeq, alu_cmpule, alu_cmplt, alu_cmple
  } alu_func_t;

  // Low two bits of the branch function
  typedef enum logic [1:0] {
    br_lbc = 2'b00,
    br_eq  = 2'b01,
    br_lt  = 2'b10,
    br_le  = 2'b11
  } br_test_t;

  typedef struct packed {
    logic     invert;
    br_test_t test;
  } br_func_t;

  typedef enum logic [1:0] {
    kind_alu    = 2'b00,
    kind_branch = 2'b01,
    kind_mult   = 2'b10
  } ex_kind_t;

  typedef enum logic [1:0] {
    br_none      = 2'b00,
    br_taken     = 2'b01,
    br_not_taken = 2'b10,
    br_halt      = 2'b11
  } br_result_t;

  typedef struct packed {
    logic                valid;
    ex_kind_t            kind;
    alu_func_t           alu_func;
    br_func_t            br_func;
    logic [xlen-1:0]     opa;
    logic [xlen-1:0]     opb;
    logic [xlen-1:0]     npc;
    logic [tag_bits-1:0] dest;
    logic                predicted_taken;
    logic                is_link;
    logic                is_halt;
  } ex_cmd_t;

  typedef struct packed {
    logic                valid;
    logic [xlen-1:0]     npc;
    logic [tag_bits-1:0] dest;
  } mult_tag_t;

  typedef struct packed {
    logic                valid;
    logic [tag_bits-1:0] dest;
    logic [xlen-1:0]     result;
    logic [xlen-1:0]     npc;
    logic [xlen-1:0]     target;
    br_result_t          br_result;
    logic                mispredict;
  } cdb_t;

endpackage

//--- hdl/ex_stage.sv
// ******************************
// Execute stage top level.
// One issue bus in, one completion bus out; issue_stall tells the
// source to hold its command.
// ******************************

`timescale 1ns/10ps

module ex_stage (
  input  logic            clock,
  input  logic            reset,
  input  ex_pkg::ex_cmd_t cmd,
  input  logic            wb_stall,
  output ex_pkg::cdb_t    cdb,
  output logic            issue_stall
);

  import ex_pkg::*;

  logic [xlen-1:0] alu_result;
  logic            cond;
  logic            mult_start;
  mult_tag_t       mult_tag_in;
  logic [xlen-1:0] product;
  mult_tag_t       out_tag;

  ex_alu i_alu (
    .opa    (cmd.opa),
    .opb    (cmd.opb),
    .func   (cmd.alu_func),
    .result (alu_result)
  );

  ex_branch_cond i_branch_cond (
    .opa  (cmd.opa),
    .func (cmd.br_func),
    .cond (cond)
  );

  // Multiply accepted only on a cycle without issue stall
  assign mult_start  = cmd.valid && (cmd.kind == kind_mult) && !issue_stall;
  assign mult_tag_in = '{valid: mult_start, npc: cmd.npc, dest: cmd.dest};

  mult_pipe i_mult_pipe (
    .clock   (clock),
    .reset   (reset),
    .stall   (wb_stall),
    .start   (mult_start),
    .mplier  (cmd.opb),
    .mcand   (cmd.opa),
    .tag_in  (mult_tag_in),
    .product (product),
    .out_tag (out_tag)
  );

  ex_arbiter i_arbiter (
    .cmd         (cmd),
    .alu_result  (alu_result),
    .cond        (cond),
    .product     (product),
    .mult_tag    (out_tag),
    .wb_stall    (wb_stall),
    .cdb         (cdb),
    .issue_stall (issue_stall)
  );

endmodule

//--- hdl/mult_pipe.sv
// ******************************
// Four-stage pipelined 64-bit multiplier.
// Returns the low 64 bits of the product four edges after start,
// with the tag carried alongside. stall freezes all stages.
// ******************************

`timescale 1ns/10ps

module mult_pipe (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    stall,
  input  logic                    start,
  input  logic [ex_pkg::xlen-1:0] mplier,
  input  logic [ex_pkg::xlen-1:0] mcand,
  input  ex_pkg::mult_tag_t       tag_in,
  output logic [ex_pkg::xlen-1:0] product,
  output ex_pkg::mult_tag_t       out_tag
);

  import ex_pkg::*;

  logic [xlen-1:0] product_chain [0:mult_stages];
  logic [xlen-1:0] mplier_chain  [0:mult_stages];
  logic [xlen-1:0] mcand_chain   [0:mult_stages];
  mult_tag_t       tag_chain     [0:mult_stages];

  assign product_chain[0] = '0;
  assign mplier_chain[0]  = mplier;
  assign mcand_chain[0]   = mcand;
  assign tag_chain[0]     = '{valid: start, npc: tag_in.npc, dest: tag_in.dest};

  for (genvar i = 0; i < mult_stages; i++) begin : g_stage
    mult_stage i_stage (
      .clock       (clock),
      .reset       (reset),
      .stall       (stall),
      .start       (tag_chain[i].valid),
      .product_in  (product_chain[i]),
      .mplier_in   (mplier_chain[i]),
      .mcand_in    (mcand_chain[i]),
      .tag_in      (tag_chain[i]),
      .product_out (product_chain[i+1]),
      .mplier_out  (mplier_chain[i+1]),
      .mcand_out   (mcand_chain[i+1]),
      .tag_out     (tag_chain[i+1])
    );
  end

  assign product = product_chain[mult_stages];
  assign out_tag = tag_chain[mult_stages];

endmodule

//--- hdl/mult_stage.sv
// ******************************
// One multiplier stage: adds the partial product of the next
// 16 multiplier bits to the running sum. Chained by mult_pipe;
// the whole stage holds while stall is high.
// ******************************

`timescale 1ns/10ps

module mult_stage (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    stall,
  input  logic                    start,
  input  logic [ex_pkg::xlen-1:0] product_in,
  input  logic [ex_pkg::xlen-1:0] mplier_in,
  input  logic [ex_pkg::xlen-1:0] mcand_in,
  input  ex_pkg::mult_tag_t       tag_in,
  output logic [ex_pkg::xlen-1:0] product_out,
  output logic [ex_pkg::xlen-1:0] mplier_out,
  output logic [ex_pkg::xlen-1:0] mcand_out,
  output ex_pkg::mult_tag_t       tag_out
);

  import ex_pkg::*;

  logic [xlen-1:0]     partial_product;
  logic [xlen-1:0]     prod_in_q;
  logic [xlen-1:0]     partial_q;
  logic [xlen-1:0]     npc_q;
  logic [tag_bits-1:0] dest_q;
  logic                valid_q;

  assign partial_product = mplier_in[mult_chunk-1:0] * mcand_in;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= start;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      prod_in_q  <= product_in;
      partial_q  <= partial_product;
      mplier_out <= mplier_in >> mult_chunk;
      mcand_out  <= mcand_in << mult_chunk;
      npc_q      <= tag_in.npc;
      dest_q     <= tag_in.dest;
    end
  end

  // Sum is formed on the way out so the next stage sees it directly
  assign product_out = prod_in_q + partial_q;
  assign tag_out = '{valid: valid_q, npc: npc_q, dest: dest_q};

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the execute-stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f src.f \
  --top-module tb_ex_stage \
  -o sim_ex_stage

# A fatal check makes the simulator exit nonzero, so the log decides
./obj_dir/sim_ex_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
  echo "Simulation ended without a pass message"
  exit 1
fi
echo "Simulation passed"

//--- src.f
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_branch_cond.sv
hdl/mult_stage.sv
hdl/mult_pipe.sv
hdl/ex_arbiter.sv
hdl/ex_stage.sv
tests/tb_ex_stage.sv

//--- tests/tb_ex_stage.sv
// ******************************
// Directed testbench for the execute stage. Drives the issue bus
// on the falling edge and checks the completion bus against a
// reference model of the ALU, branch and multiply rules.
// ******************************

`timescale 1ns/10ps

module tb_ex_stage;

  import ex_pkg::*;

  localparam int period = 4;
  localparam int max_wait = 16;
  localparam int mid_stall = 3;
  localparam int hold = 3;
  // Reset, ALU, branch, single, burst, then both stall phases
  localparam int test_cycles = 5 + 16 * 9 + 81 + 8 + 10 + (8 + mid_stall) + (8 + hold);

  logic        clock;
  logic        reset;
  ex_cmd_t     cmd;
  logic        wb_stall;
  cdb_t        cdb;
  logic        issue_stall;
  logic [31:0] lfsr_state;

  ex_stage i_dut (
    .clock       (clock),
    .reset       (reset),
    .cmd         (cmd),
    .wb_stall    (wb_stall),
    .cdb         (cdb),
    .issue_stall (issue_stall)
  );

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  initial begin
    #((test_cycles + 50) * period);
    $display("Timeout: the tests did not finish within the expected time");
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[62:0], lfsr_state[0]};
    end
    return w;
  endfunction

  function automatic logic [63:0] expected_alu(input alu_func_t f, input logic [63:0] a,
                                               input logic [63:0] b);
    logic [5:0] sh;
    sh = b[5:0];
    case (f)
      alu_add:    return a + b;
      alu_sub:    return a - b;
      alu_and:    return a & b;
      alu_bic:    return a & ~b;
      alu_bis:    return a | b;
      alu_ornot:  return a | ~b;
      alu_xor:    return a ^ b;
      alu_eqv:    return ~(a ^ b);
      alu_srl:    return a >> sh;
      alu_sll:    return a << sh;
      alu_sra:    return $signed(a) >>> sh;
      alu_cmpult: return 64'(a < b);
      alu_cmpeq:  return 64'(a == b);
      alu_cmpule: return 64'(a <= b);
      alu_cmplt:  return 64'($signed(a) < $signed(b));
      default:    return 64'($signed(a) <= $signed(b));
    endcase
  endfunction

  // Low two bits pick the test, top bit inverts
  function automatic logic branch_taken(input logic [2:0] f, input logic [63:0] a);
    logic t;
    case (f[1:0])
      2'd0:    t = !a[0];
      2'd1:    t = (a == '0);
      2'd2:    t = a[63];
      default: t = ($signed(a) <= 64'sd0);
    endcase
    return t ^ f[2];
  endfunction

  function automatic ex_cmd_t make_cmd(input ex_kind_t kind, input logic [63:0] a,
                                       input logic [63:0] b);
    ex_cmd_t c;
    c = '0;
    c.valid = 1'b1;
    c.kind = kind;
    c.opa = a;
    c.opb = b;
    c.npc = rand_bits(64);
    c.dest = 8'(rand_bits(8));
    return c;
  endfunction

  task automatic check_equal(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("** Error [%s] expected %h, actual %h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_for_cdb(input string name, output int cycles);
    cycles = 0;
    while (!cdb.valid) begin
      if (cycles == max_wait) begin
        $display("%s: no result on the completion bus after %0d cycles", name, max_wait);
        $display("CHECKS FAILED");
        $fatal(1, "missing result");
      end else begin
        @(negedge clock);
        #1;
        cycles++;
      end
    end
  endtask

  task automatic test_after_reset();
    @(negedge clock);
    #1;
    check_equal("reset cdb valid", 64'd0, 64'(cdb.valid));
    check_equal("reset issue_stall", 64'd0, 64'(issue_stall));
  endtask

  task automatic test_alu();
    logic [63:0] edge_a [5] = '{64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 64'd5,
                                64'h7fff_ffff_ffff_ffff, 64'hffff_ffff_ffff_fffb};
    logic [63:0] edge_b [5] = '{64'd63, 64'd1, 64'd5, 64'h8000_0000_0000_0000, 64'd5};
    logic [63:0] a;
    logic [63:0] b;
    for (int i = 0; i < 16; i++) begin
      for (int j = 0; j < 9; j++) begin
        a = (j < 5) ? edge_a[j] : rand_bits(64);
        b = (j < 5) ? edge_b[j] : rand_bits(64);
        @(negedge clock);
        cmd = make_cmd(kind_alu, a, b);
        cmd.alu_func = alu_func_t'(5'(i));
        #1;
        check_equal($sformatf("alu %0d valid", i), 64'd1, 64'(cdb.valid));
        check_equal($sformatf("alu %0d result", i), expected_alu(cmd.alu_func, a, b), cdb.result);
        check_equal($sformatf("alu %0d dest", i), 64'(cmd.dest), 64'(cdb.dest));
        check_equal($sformatf("alu %0d npc", i), cmd.npc, cdb.npc);
      end
    end
  endtask

  task automatic test_branch();
    logic [63:0] ops [5] = '{64'd0, 64'hffff_ffff_ffff_fff8, 64'd42, 64'd17,
                             64'h8000_0000_0000_0001};
    logic [2:0]  f;
    logic        taken;
    logic [63:0] disp;
    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < 10; j++) begin
        f = 3'(i);
        taken = branch_taken(f, ops[j / 2]);
        disp = rand_bits(64);
        @(negedge clock);
        cmd = make_cmd(kind_branch, ops[j / 2], disp);
        cmd.br_func.invert = f[2];
        cmd.br_func.test = br_test_t'(f[1:0]);
        cmd.predicted_taken = j[0];
        cmd.is_link = j[1];
        #1;
        check_equal("branch outcome", 64'(taken ? br_taken : br_not_taken),
                    64'(cdb.br_result));
        check_equal("branch mispredict", 64'(taken != cmd.predicted_taken),
                    64'(cdb.mispredict));
        check_equal("branch result", cmd.is_link ? cmd.npc : ops[j / 2] + disp, cdb.result);
        check_equal("branch target", ops[j / 2] + disp, cdb.target);
      end
    end
    @(negedge clock);
    cmd = make_cmd(kind_alu, rand_bits(64), rand_bits(64));
    cmd.is_halt = 1'b1;
    #1;
    check_equal("halt outcome", 64'(br_halt), 64'(cdb.br_result));
    @(negedge clock);
    cmd = '0;
  endtask

  task automatic test_mult_single();
    ex_cmd_t sent;
    int      cycles;
    @(negedge clock);
    cmd = make_cmd(kind_mult, rand_bits(64), rand_bits(64));
    sent = cmd;
    #1;
    check_equal("single mult accept", 64'd0, 64'(issue_stall));
    check_equal("single mult no early result", 64'd0, 64'(cdb.valid));
    @(negedge clock);
    cmd = '0;
    #1;
    wait_for_cdb("single mult", cycles);
    // One edge already passed at acceptance
    check_equal("single mult latency", 64'd4, 64'(cycles + 1));
    check_equal("single mult product", sent.opa * sent.opb, cdb.result);
    check_equal("single mult dest", 64'(sent.dest), 64'(cdb.dest));
    check_equal("single mult npc", sent.npc, cdb.npc);
    check_equal("single mult outcome", 64'(br_none), 64'(cdb.br_result));
    check_equal("single mult issue_stall", 64'd1, 64'(issue_stall));
    @(negedge clock);
    #1;
    check_equal("single mult consumed", 64'd0, 64'(cdb.valid));
  endtask

  task automatic test_mult_burst();
    ex_cmd_t sent [4];
    ex_cmd_t alu_cmd;
    for (int k = 0; k < 4; k++) begin
      @(negedge clock);
      cmd = make_cmd(kind_mult, rand_bits(64), rand_bits(64));
      sent[k] = cmd;
      #1;
      check_equal("burst accept", 64'd0, 64'(issue_stall));
    end
    @(negedge clock);
    alu_cmd = make_cmd(kind_alu, rand_bits(64), rand_bits(64));
    alu_cmd.alu_func = alu_xor;
    cmd = alu_cmd;
    // ALU command held while the products drain
    for (int k = 0; k < 4; k++) begin
      if (k > 0) begin
        @(negedge clock);
      end
      #1;
      check_equal("burst valid", 64'd1, 64'(cdb.valid));
      check_equal($sformatf("burst product %0d", k), sent[k].opa * sent[k].opb, cdb.result);
      check_equal("burst dest", 64'(sent[k].dest), 64'(cdb.dest));
      check_equal("burst issue_stall", 64'd1, 64'(issue_stall));
    end
    @(negedge clock);
    #1;
    check_equal("held alu issue_stall", 64'd0, 64'(issue_stall));
    check_equal("held alu result", expected_alu(alu_xor, alu_cmd.opa, alu_cmd.opb),
                cdb.result);
    check_equal("held alu dest", 64'(alu_cmd.dest), 64'(cdb.dest));
    @(negedge clock);
    cmd = '0;
  endtask

  task automatic test_wb_stall();
    ex_cmd_t sent;
    int      edges;
    int      cycles;
    @(negedge clock);
    cmd = make_cmd(kind_mult, rand_bits(64), rand_bits(64));
    sent = cmd;
    @(negedge clock);
    cmd = '0;
    edges = 1;
    for (int s = 0; s < mid_stall; s++) begin
      @(negedge clock);
      wb_stall = 1'b1;
      edges++;
      #1;
      check_equal("mid stall issue_stall", 64'd1, 64'(issue_stall));
      check_equal("mid stall cdb idle", 64'd0, 64'(cdb.valid));
    end
    @(negedge clock);
    wb_stall = 1'b0;
    edges++;
    #1;
    wait_for_cdb("stalled mult", cycles);
    check_equal("stalled mult latency", 64'(4 + mid_stall), 64'(edges + cycles));
    check_equal("stalled mult product", sent.opa * sent.opb, cdb.result);

    // Second multiply, held on the bus by writeback
    @(negedge clock);
    cmd = make_cmd(kind_mult, rand_bits(64), rand_bits(64));
    sent = cmd;
    #1;
    check_equal("stalled mult consumed", 64'd0, 64'(cdb.valid));
    @(negedge clock);
    cmd = '0;
    repeat (2) @(negedge clock);
    @(negedge clock);
    wb_stall = 1'b1;
    for (int h = 0; h <= hold; h++) begin
      if (h > 0) begin
        @(negedge clock);
      end
      wb_stall = (h < hold);
      #1;
      check_equal("hold valid", 64'd1, 64'(cdb.valid));
      check_equal("hold product", sent.opa * sent.opb, cdb.result);
      check_equal("hold dest", 64'(sent.dest), 64'(cdb.dest));
      check_equal("hold issue_stall", 64'd1, 64'(issue_stall));
    end
    @(negedge clock);
    #1;
    check_equal("hold released", 64'd0, 64'(cdb.valid));
  endtask

  initial begin
    reset = 1'b1;
    wb_stall = 1'b0;
    cmd = '0;
    lfsr_state = 32'hea9d;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    test_after_reset();
    test_alu();
    test_branch();
    test_mult_single();
    test_mult_burst();
    test_wb_stall();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
